// File: hdl/exerionPkg.sv
`default_nettype none

package exerionPkg;

	// ============================================================
	// video timing
	// ============================================================
	localparam int hBits = 9;
	localparam int vBits = 8;

	localparam logic [hBits-1:0] hStart = 9'd88;   // line starts here after wrap
	localparam logic [hBits-1:0] hLast  = 9'd511;

	localparam logic [hBits-1:0] hBlankLo = 9'd90;  // visible from 90
	localparam logic [hBits-1:0] hBlankHi = 9'd437; // through 437
	localparam logic [vBits-1:0] vBlankLo = 8'd16;
	localparam logic [vBits-1:0] vBlankHi = 8'd239;

	localparam logic [hBits-1:0] hSyncFirst = 9'd464; // active high pulse
	localparam logic [hBits-1:0] hSyncLast  = 9'd479;
	localparam logic [vBits-1:0] vSyncFirst = 8'd248; // active low pulse
	localparam logic [vBits-1:0] vSyncLast  = 8'd251;

	// counter value to rgb
	localparam int pixelLatency = 5;

	// ============================================================
	// memories and address maps
	// ============================================================
	localparam int tileAddrBits = 11;  // 5 row bits, 6 column bits
	localparam int charAddrBits = 13;
	localparam int lookAddrBits = 8;
	localparam int colAddrBits  = 5;

	// download port, 14 bit byte addresses
	localparam logic [13:0] dnCharBase = 14'h0000;
	localparam logic [13:0] dnLookBase = 14'h2000; // low nibble only
	localparam logic [13:0] dnColBase  = 14'h2100; // {blue, green, red}

	// host side
	localparam logic [15:0] hostTileBase = 16'h8000; // up to 0x87FF
	localparam logic [15:0] hostCtrlAddr = 16'hA000;

endpackage

`default_nettype wire

// File: hdl/videoTiming.sv
`default_nettype none

module videoTiming import exerionPkg::*; (
	input  wire              clk2_6MHZ,
	input  wire              RAMB,
	output logic [hBits-1:0] pixH_o,
	output logic [vBits-1:0] pixV_o,
	output logic             blank_o,
	output logic             hSync_o,
	output logic             vSync_o,
	output logic             hBlank_o,
	output logic             vBlank_o
);

	logic hBlankNow;
	logic vBlankNow;
	logic hSyncNow;
	logic vSyncNow;

	// bit i holds the decode from i+1 cycles back
	logic [pixelLatency-1:0] hBlankDly;
	logic [pixelLatency-1:0] vBlankDly;
	logic [pixelLatency-1:0] hSyncDly;
	logic [pixelLatency-1:0] vSyncDly;

	// ============================================================
	// pixel counters
	// ============================================================
	// 88..511 gives 424 clocks per line, 256 lines per frame
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			pixH_o <= hStart;
			pixV_o <= '0;
		end else if (pixH_o == hLast) begin
			pixH_o <= hStart;
			pixV_o <= pixV_o + 1'b1; // wraps 255 to 0
		end else begin
			pixH_o <= pixH_o + 1'b1;
		end
	end

	// decodes of the current counter position
	assign hBlankNow = (pixH_o < hBlankLo) || (pixH_o > hBlankHi);
	assign vBlankNow = (pixV_o < vBlankLo) || (pixV_o > vBlankHi);
	assign hSyncNow  = (pixH_o >= hSyncFirst) && (pixH_o <= hSyncLast);
	assign vSyncNow  = !((pixV_o >= vSyncFirst) && (pixV_o <= vSyncLast));

	// ============================================================
	// delay line to match the pixel pipeline
	// ============================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			// what (hStart, 0) decodes to
			hBlankDly <= '1;
			vBlankDly <= '1;
			hSyncDly  <= '0;
			vSyncDly  <= '1;
		end else begin
			hBlankDly <= {hBlankDly[pixelLatency-2:0], hBlankNow};
			vBlankDly <= {vBlankDly[pixelLatency-2:0], vBlankNow};
			hSyncDly  <= {hSyncDly[pixelLatency-2:0], hSyncNow};
			vSyncDly  <= {vSyncDly[pixelLatency-2:0], vSyncNow};
		end
	end

	// priority register samples fgColour three clocks after its position,
	// so it wants the blank from three clocks back
	assign blank_o = hBlankDly[pixelLatency-3] | vBlankDly[pixelLatency-3];

	// leave together with the rgb of the same pixel
	assign hBlank_o = hBlankDly[pixelLatency-1];
	assign vBlank_o = vBlankDly[pixelLatency-1];
	assign hSync_o  = hSyncDly[pixelLatency-1];
	assign vSync_o  = vSyncDly[pixelLatency-1];

endmodule

`default_nettype wire

// File: hdl/hostDecode.sv
`default_nettype none

module hostDecode import exerionPkg::*; (
	input  wire        clk2_6MHZ,
	input  wire        RAMB,
	input  wire [15:0] hostAddr_i,
	input  wire [7:0]  hostData_i,
	input  wire        hostWr_i,
	input  wire [13:0] dnAddr_i,
	input  wire        dnWr_i,
	output logic       tileWe_o,
	output logic       charWe_o,
	output logic       lookWe_o,
	output logic       colWe_o,
	output logic [1:0] lookBank_o,
	output logic       charBank_o
);

	logic ctrlWr;

	// ============================================================
	// host side
	// ============================================================
	// 2 KB window at 0x8000
	assign tileWe_o = hostWr_i &&
		(hostAddr_i[15:tileAddrBits] == hostTileBase[15:tileAddrBits]);
	assign ctrlWr = hostWr_i && (hostAddr_i == hostCtrlAddr); // full decode

	// control latch
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			lookBank_o <= '0;
			charBank_o <= 1'b0;
		end else if (ctrlWr) begin
			lookBank_o <= hostData_i[2:1]; // lookup prom A7:A6
			charBank_o <= hostData_i[3];   // char rom A12
		end
	end

	// ============================================================
	// download regions
	// ============================================================
	assign charWe_o = dnWr_i &&
		(dnAddr_i[13:charAddrBits] == dnCharBase[13:charAddrBits]);
	assign lookWe_o = dnWr_i &&
		(dnAddr_i[13:lookAddrBits] == dnLookBase[13:lookAddrBits]);
	assign colWe_o = dnWr_i &&
		(dnAddr_i[13:colAddrBits] == dnColBase[13:colAddrBits]); // 0x2100..0x211F

endmodule

`default_nettype wire

// File: hdl/tileFetch.sv
`default_nettype none

module tileFetch import exerionPkg::*; (
	input  wire                     clk2_6MHZ,
	input  wire                     tileWe_i,
	input  wire                     charWe_i,
	input  wire                     lookWe_i,
	input  wire [tileAddrBits-1:0]  hostAddr_i,
	input  wire [7:0]               hostData_i,
	input  wire [charAddrBits-1:0]  dnAddr_i,
	input  wire [7:0]               dnData_i,
	input  wire [hBits-1:0]         pixH_i,
	input  wire [vBits-1:0]         pixV_i,
	input  wire [1:0]               lookBank_i,
	input  wire                     charBank_i,
	output logic [3:0]              fgColour_o
);

	logic [7:0] tileRam [2**tileAddrBits];
	logic [7:0] charRom [2**charAddrBits];
	logic [3:0] lookRom [2**lookAddrBits];

	// stage 1 results
	logic [7:0] tileCode;
	logic [2:0] vFine1;
	logic [2:0] hFine1;

	// stage 2 results
	logic [7:0] romByte;
	logic [1:0] hSel2;
	logic [3:0] codeHi2;

	// stage 3 inputs
	logic [1:0]              pixel;
	logic [charAddrBits-1:0] charAddr;
	logic [lookAddrBits-1:0] lookAddr;

	// ============================================================
	// memory writes
	// ============================================================
	// tile ram is dual ported so the display never waits on the host
	always_ff @(posedge clk2_6MHZ) begin
		if (tileWe_i) begin
			tileRam[hostAddr_i] <= hostData_i;
		end
	end

	always_ff @(posedge clk2_6MHZ) begin
		if (charWe_i) begin
			charRom[dnAddr_i] <= dnData_i;
		end
	end

	always_ff @(posedge clk2_6MHZ) begin
		if (lookWe_i) begin
			lookRom[dnAddr_i[lookAddrBits-1:0]] <= dnData_i[3:0]; // 4 bit prom
		end
	end

	// ============================================================
	// stage 1 tile code
	// ============================================================
	always_ff @(posedge clk2_6MHZ) begin
		tileCode <= tileRam[{pixV_i[7:3], pixH_i[8:3]}]; // 32 rows x 64 columns
		vFine1   <= pixV_i[2:0];
		hFine1   <= pixH_i[2:0];
	end

	// ============================================================
	// stage 2 character rom
	// ============================================================
	// one byte covers four pixels, two planes
	assign charAddr = {charBank_i, tileCode[7:4], vFine1, tileCode[3:0], hFine1[2]};

	always_ff @(posedge clk2_6MHZ) begin
		romByte <= charRom[charAddr];
		hSel2   <= hFine1[1:0];
		codeHi2 <= tileCode[7:4]; // colour group for the lookup
	end

	// ============================================================
	// stage 3 pixel select and lookup
	// ============================================================
	// plane 0 in the low nibble, plane 1 in the high nibble
	always_comb begin
		case (hSel2)
			2'd0:    pixel = {romByte[4], romByte[0]};
			2'd1:    pixel = {romByte[5], romByte[1]};
			2'd2:    pixel = {romByte[6], romByte[2]};
			default: pixel = {romByte[7], romByte[3]};
		endcase
	end

	assign lookAddr = {lookBank_i, pixel, codeHi2};

	always_ff @(posedge clk2_6MHZ) begin
		fgColour_o <= lookRom[lookAddr]; // 0 means transparent
	end

endmodule

`default_nettype wire

// File: hdl/paletteOut.sv
`default_nettype none

module paletteOut import exerionPkg::*; (
	input  wire                   clk2_6MHZ,
	input  wire                   RAMB,
	input  wire                   colWe_i,
	input  wire [colAddrBits-1:0] dnAddr_i,
	input  wire [7:0]             dnData_i,
	input  wire [3:0]             fgColour_i,
	input  wire                   blank_i,
	output logic [2:0]            red_o,
	output logic [2:0]            green_o,
	output logic [1:0]            blue_o
);

	logic [7:0]             colRom [2**colAddrBits];
	logic [colAddrBits-1:0] clrAddr;

	// ============================================================
	// colour prom load
	// ============================================================
	always_ff @(posedge clk2_6MHZ) begin
		if (colWe_i) begin
			colRom[dnAddr_i] <= dnData_i;
		end
	end

	// ============================================================
	// priority and blank
	// ============================================================
	// foreground uses the upper half of the palette,
	// everything else falls back to backdrop entry 0
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			clrAddr <= '0;
		end else if (blank_i) begin
			clrAddr <= '0;
		end else if (fgColour_i != 4'd0) begin
			clrAddr <= {1'b1, fgColour_i};
		end else begin
			clrAddr <= '0; // transparent
		end
	end

	// ============================================================
	// rgb register
	// ============================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end else begin
			{blue_o, green_o, red_o} <= colRom[clrAddr]; // 2-3-3 packing in the prom
		end
	end

endmodule

`default_nettype wire

// File: hdl/exerionVideo.sv
`default_nettype none

module exerionVideo import exerionPkg::*; (
	input  wire        clk2_6MHZ,
	input  wire        RAMB,
	input  wire [15:0] hostAddr_i,
	input  wire [7:0]  hostData_i,
	input  wire        hostWr_i,
	input  wire [13:0] dnAddr_i,
	input  wire [7:0]  dnData_i,
	input  wire        dnWr_i,
	output wire [2:0]  red_o,
	output wire [2:0]  green_o,
	output wire [1:0]  blue_o,
	output wire        hSync_o,
	output wire        vSync_o,
	output wire        hBlank_o,
	output wire        vBlank_o
);

	wire [hBits-1:0] pixH;
	wire [vBits-1:0] pixV;
	wire             blank;   // aligned to the priority stage
	wire             tileWe;
	wire             charWe;
	wire             lookWe;
	wire             colWe;
	wire [1:0]       lookBank;
	wire             charBank;
	wire [3:0]       fgColour;

	// ============================================================
	// timing and host side
	// ============================================================
	videoTiming timing0 (
		.clk2_6MHZ (clk2_6MHZ),
		.RAMB      (RAMB),
		.pixH_o    (pixH),
		.pixV_o    (pixV),
		.blank_o   (blank),
		.hSync_o   (hSync_o),
		.vSync_o   (vSync_o),
		.hBlank_o  (hBlank_o),
		.vBlank_o  (vBlank_o)
	);

	hostDecode decode0 (
		.clk2_6MHZ  (clk2_6MHZ),
		.RAMB       (RAMB),
		.hostAddr_i (hostAddr_i),
		.hostData_i (hostData_i),
		.hostWr_i   (hostWr_i),
		.dnAddr_i   (dnAddr_i),
		.dnWr_i     (dnWr_i),
		.tileWe_o   (tileWe),
		.charWe_o   (charWe),
		.lookWe_o   (lookWe),
		.colWe_o    (colWe),
		.lookBank_o (lookBank),
		.charBank_o (charBank)
	);

	// ============================================================
	// pixel pipeline
	// ============================================================
	tileFetch fetch0 (
		.clk2_6MHZ  (clk2_6MHZ),
		.tileWe_i   (tileWe),
		.charWe_i   (charWe),
		.lookWe_i   (lookWe),
		.hostAddr_i (hostAddr_i[tileAddrBits-1:0]),
		.hostData_i (hostData_i),
		.dnAddr_i   (dnAddr_i[charAddrBits-1:0]),
		.dnData_i   (dnData_i),
		.pixH_i     (pixH),
		.pixV_i     (pixV),
		.lookBank_i (lookBank),
		.charBank_i (charBank),
		.fgColour_o (fgColour)
	);

	paletteOut palette0 (
		.clk2_6MHZ  (clk2_6MHZ),
		.RAMB       (RAMB),
		.colWe_i    (colWe),
		.dnAddr_i   (dnAddr_i[colAddrBits-1:0]),
		.dnData_i   (dnData_i),
		.fgColour_i (fgColour),
		.blank_i    (blank),
		.red_o      (red_o),
		.green_o    (green_o),
		.blue_o     (blue_o)
	);

endmodule

`default_nettype wire

// File: tb/exerionVideo_chk.sv
`default_nettype none

module exerionVideoChk import exerionPkg::*; (
	input wire             clk2_6MHZ,
	input wire             RAMB,
	input wire [hBits-1:0] pixH_i,
	input wire [vBits-1:0] pixV_i,
	input wire             hSync_i,
	input wire             vSync_i,
	input wire             hBlank_i,
	input wire             vBlank_i,
	input wire [2:0]       red_i,
	input wire [2:0]       green_i,
	input wire [1:0]       blue_i
);

	int   errCount = 0;
	int   runCnt;
	int   hHigh;   // consecutive high samples of hSync
	int   hGap;    // samples since the last hSync rise
	int   vLow;
	int   vGap;
	logic hSeen;
	logic vSeen;
	logic hPrev;
	logic vPrev;
	logic hDec;
	logic vDec;

	assign hDec = (pixH_i < hBlankLo) || (pixH_i > hBlankHi);
	assign vDec = (pixV_i < vBlankLo) || (pixV_i > vBlankHi);

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			runCnt <= 0;
			hHigh  <= 0;
			hGap   <= 0;
			vLow   <= 0;
			vGap   <= 0;
			hSeen  <= 1'b0;
			vSeen  <= 1'b0;
			hPrev  <= 1'b0;
			vPrev  <= 1'b1;
		end else begin
			runCnt <= (runCnt < 16) ? runCnt + 1 : runCnt;
			hPrev  <= hSync_i;
			vPrev  <= vSync_i;
			hHigh  <= hSync_i ? hHigh + 1 : 0;
			vLow   <= vSync_i ? 0 : vLow + 1;
			if (!hPrev && hSync_i) begin
				hGap  <= 1;
				hSeen <= 1'b1;
			end else begin
				hGap <= hGap + 1;
			end
			if (vPrev && !vSync_i) begin
				vGap  <= 1;
				vSeen <= 1'b1;
			end else begin
				vGap <= vGap + 1;
			end
		end
	end

	// ============================================================
	// sync and blank timing
	// ============================================================
	assert property (@(posedge clk2_6MHZ) !RAMB |-> (hBlank_i && vBlank_i && !hSync_i &&
		vSync_i && {blue_i, green_i, red_i} == 8'd0))
		else begin errCount++; $error("outputs left their reset state during reset"); end

	assert property (@(posedge clk2_6MHZ) disable iff (!RAMB) (hPrev && !hSync_i) |-> hHigh == 16)
		else begin errCount++; $error("hSync pulse is not 16 cycles wide"); end

	assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(!hPrev && hSync_i && hSeen) |-> hGap == (hLast - hStart + 1))
		else begin errCount++; $error("hSync period is not one line"); end

	assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(!vPrev && vSync_i) |-> vLow == 4 * (hLast - hStart + 1))
		else begin errCount++; $error("vSync low phase is not four lines"); end

	assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(vPrev && !vSync_i && vSeen) |-> vGap == 256 * (hLast - hStart + 1))
		else begin errCount++; $error("vSync period is not one frame"); end

	// blanks trail the counters by the pipeline depth
	assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(runCnt > 6) |-> (hBlank_i == $past(hDec, 5)) && (vBlank_i == $past(vDec, 5)))
		else begin errCount++; $error("blank outputs do not follow the counter bounds"); end

endmodule

bind exerionVideo exerionVideoChk chk0 (
	.clk2_6MHZ (clk2_6MHZ),
	.RAMB      (RAMB),
	.pixH_i    (pixH),
	.pixV_i    (pixV),
	.hSync_i   (hSync_o),
	.vSync_i   (vSync_o),
	.hBlank_i  (hBlank_o),
	.vBlank_i  (vBlank_o),
	.red_i     (red_o),
	.green_i   (green_o),
	.blue_i    (blue_o)
);

`default_nettype wire

// File: tb/exerionVideoTb.sv
`default_nettype none

module exerionVideoTb import exerionPkg::*; ();

	logic        clk2_6MHZ;
	logic        RAMB;
	logic [15:0] hostAddr;
	logic [7:0]  hostData;
	logic        hostWr;
	logic [13:0] dnAddr;
	logic [7:0]  dnData;
	logic        dnWr;
	wire  [2:0]  red;
	wire  [2:0]  green;
	wire  [1:0]  blue;
	wire         hSync;
	wire         vSync;
	wire         hBlank;
	wire         vBlank;

	// own copies of every memory and of the control latch
	logic [7:0]  charMem [8192];
	logic [3:0]  lookMem [256];
	logic [7:0]  colMem [32];
	logic [7:0]  tileMem [2048];
	logic [7:0]  codes [64];
	logic [1:0]  lookBank;
	logic        charBank;
	logic [31:0] rndState;

	logic [8:0]  mH;       // counter mirror
	logic [7:0]  mV;
	int          frameNo;
	int          cycles;
	int          timeoutLimit;
	logic [7:0]  expRgb [5];
	logic        expChk [5];
	int          expCnt;

	exerionVideo dut0 (
		.clk2_6MHZ (clk2_6MHZ), .RAMB (RAMB),
		.hostAddr_i (hostAddr), .hostData_i (hostData), .hostWr_i (hostWr),
		.dnAddr_i (dnAddr), .dnData_i (dnData), .dnWr_i (dnWr),
		.red_o (red), .green_o (green), .blue_o (blue),
		.hSync_o (hSync), .vSync_o (vSync), .hBlank_o (hBlank), .vBlank_o (vBlank)
	);

	always #2 clk2_6MHZ = ~clk2_6MHZ;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] nextByte();
		rndState = xorshift32(rndState);
		return rndState[15:8];
	endfunction

	// colour entry expected for one screen position
	function automatic logic [7:0] predictRgb(input logic [8:0] h, input logic [7:0] v);
		logic [7:0] code;
		logic [7:0] romByte;
		logic [1:0] pixel;
		logic [3:0] look;
		if (h < hBlankLo || h > hBlankHi || v < vBlankLo || v > vBlankHi) return colMem[0];
		code     = tileMem[{v[7:3], h[8:3]}];
		romByte  = charMem[{charBank, code[7:4], v[2:0], code[3:0], h[2]}];
		pixel[1] = romByte[{1'b1, h[1:0]}];
		pixel[0] = romByte[{1'b0, h[1:0]}];
		look     = lookMem[{lookBank, pixel, code[7:4]}];
		if (look == 4'd0) return colMem[0]; // transparent shows the backdrop
		return colMem[{1'b1, look}];
	endfunction

	task automatic download(input logic [13:0] addr, input logic [7:0] data);
		@(posedge clk2_6MHZ);
		#1;
		dnAddr = addr;
		dnData = data;
		dnWr   = 1'b1;
	endtask

	task automatic hostWrite(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk2_6MHZ);
		#1;
		hostAddr = addr;
		hostData = data;
		hostWr   = 1'b1;
	endtask

	task automatic releaseStrobes();
		@(posedge clk2_6MHZ);
		#1;
		dnWr   = 1'b0;
		hostWr = 1'b0;
	endtask

	task automatic loadMemories();
		logic [7:0] b;
		for (int a = 0; a < 8192; a++) begin
			charMem[a] = nextByte();
			download(dnCharBase + 14'(a), charMem[a]);
		end
		for (int a = 0; a < 256; a++) begin
			b = nextByte();
			lookMem[a] = b[3:0];
			download(dnLookBase + 14'(a), b);
		end
		for (int a = 0; a < 32; a++) begin
			colMem[a] = nextByte();
			download(dnColBase + 14'(a), colMem[a]);
		end
		releaseStrobes();
		for (int a = 0; a < 64; a++) codes[a] = nextByte();
		// 64 codes spread over the whole tile RAM, row bits mixed in
		for (int a = 0; a < 2048; a++) begin
			tileMem[a] = codes[(a ^ (a >> 6)) & 63];
			hostWrite(hostTileBase + 16'(a), tileMem[a]);
		end
		releaseStrobes();
	endtask

	// ============================================================
	// model and rgb check, on the falling edge where outputs are stable
	// ============================================================
	always @(negedge clk2_6MHZ) begin
		if (RAMB) begin
			if (expCnt == 5 && expChk[4]) begin
				assert ({blue, green, red} == expRgb[4]) else begin
					$display("MISMATCH {blue,green,red} expected 0x%h actual 0x%h",
						expRgb[4], {blue, green, red});
					$display("Test failed");
					$fatal(1, "rgb output differs from the model");
				end
			end
			for (int i = 4; i > 0; i--) begin
				expRgb[i] = expRgb[i-1];
				expChk[i] = expChk[i-1];
			end
			expRgb[0] = predictRgb(mH, mV);
			expChk[0] = (frameNo >= 1); // frame 0 is spent loading
			if (expCnt < 5) expCnt++;
			if (mH == hLast) begin
				mH = hStart;
				if (mV == 8'd255) frameNo++;
				mV = mV + 8'd1;
			end else begin
				mH = mH + 9'd1;
			end
		end
	end

	always @(posedge clk2_6MHZ) begin
		cycles++;
		if (cycles >= timeoutLimit) begin
			$display("Test failed");
			$fatal(1, "timeout, the run did not finish within %0d cycles", timeoutLimit);
		end else if (dut0.chk0.errCount != 0) begin
			$display("Test failed");
			$fatal(1, "the timing checker reported a failed assertion");
		end
	end

	initial begin
		logic [7:0] newCode;
		clk2_6MHZ = 1'b0;
		RAMB      = 1'b1;
		hostAddr  = '0;
		hostData  = '0;
		hostWr    = 1'b0;
		dnAddr    = '0;
		dnData    = '0;
		dnWr      = 1'b0;
		rndState  = 32'd53371;
		lookBank  = 2'd0;
		charBank  = 1'b0;
		mH        = hStart;
		mV        = '0;
		frameNo   = 0;
		cycles    = 0;
		expCnt    = 0;
		// three frames, loading inside the first, plus slack
		timeoutLimit = 3 * 424 * 256 + 8192 + 256 + 32 + 2048 + 2000;
		#1 RAMB = 1'b0;
		repeat (3) @(posedge clk2_6MHZ);
		#1 RAMB = 1'b1;
		loadMemories();

		// row 2 is already scanned, change shows up next frame
		wait (frameNo == 1 && mV == 8'd100);
		newCode = nextByte();
		hostWrite(hostTileBase + {5'd2, 6'd20}, newCode);
		tileMem[{5'd2, 6'd20}] = newCode;
		releaseStrobes();

		// bank switch inside vertical blank
		wait (frameNo == 1 && mV == 8'd244);
		hostWrite(hostCtrlAddr, 8'h0C);
		charBank = 1'b1;
		lookBank = 2'b10;
		releaseStrobes();

		wait (frameNo == 3);
		repeat (8) @(posedge clk2_6MHZ);
		#1;
		if (dut0.chk0.errCount != 0) begin
			$display("Test failed");
			$fatal(1, "the timing checker reported a failed assertion");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
hdl/exerionPkg.sv
hdl/videoTiming.sv
hdl/hostDecode.sv
hdl/tileFetch.sv
hdl/paletteOut.sv
hdl/exerionVideo.sv
tb/exerionVideo_chk.sv
tb/exerionVideoTb.sv

// File: Makefile
# Verilator build and run of the video testbench

VERILATOR ?= verilator
TOP       ?= exerionVideoTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?=

.PHONY: sim clean

# a $fatal in the testbench makes the binary exit nonzero
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
